// File: src.f
logic/frame_buf_pkg.sv
logic/axi_burst_pkg.sv
logic/wr_burst_ctrl.sv
logic/rd_burst_ctrl.sv
logic/frame_page_mgr.sv
logic/vfb_axi_master.sv
sim/vfb_axi_master_props.sv
sim/tb_vfb_axi_master.sv

// File: Bender.yml
package:
  name: vfb_axi_master

sources:
  # frame_buf_pkg first, axi_burst_pkg uses its address union
  - logic/frame_buf_pkg.sv
  - logic/axi_burst_pkg.sv
  - logic/wr_burst_ctrl.sv
  - logic/rd_burst_ctrl.sv
  - logic/frame_page_mgr.sv
  - logic/vfb_axi_master.sv
  - target: simulation
    files:
      - sim/vfb_axi_master_props.sv
      - sim/tb_vfb_axi_master.sv

// File: sim/tb_vfb_axi_master.sv
module tb_vfb_axi_master;

    localparam int BURST_LEN   = 8;
    localparam int LINE_PIXELS = 1920;
    localparam int PIXEL_BITS  = 32;
    localparam int BASE_SEL    = 0;
    localparam int STEP        = BURST_LEN * 8;          // 8 words per 256-bit beat
    localparam int RD_THRESH   = LINE_PIXELS * PIXEL_BITS / 128;
    localparam int FRAME_FIRST = 0;
    localparam int FRAME_END   = 256;                    // 4 bursts per frame
    localparam int CYCLE_LIMIT = 40 * 4 * 40;            // frames x bursts x cycles

    logic                         M_AXI_ACLK, M_AXI_ARESETN;
    logic                         ddr_init_done, vs_in, vs_out;
    frame_buf_pkg::frame_window_t frame_win;
    logic [8:0]                   wfifo_level, rfifo_level;
    axi_burst_pkg::addr_req_t     aw, ar;
    logic                         aw_ready, ar_ready;
    axi_burst_pkg::beat_t         w_beat, r_beat;
    logic                         wfifo_rd_req, rfifo_wr_req, frame_ready;

    logic [31:0] rng_state = 32'hd788_c076;
    int          cycle_cnt = 0;
    int          check_cnt = 0;
    int          err_cnt   = 0;
    logic        hold, block, vs_pulse;   // test phase controls
    logic        w_phase, r_phase;        // model's view of the data phases
    int          w_cnt, r_cnt;
    int          m_wr_ofs, m_rd_ofs, m_wr_page, m_rd_page, m_last_wr;
    logic        m_ready;
    int          wr_frames, rd_frames;
    logic        aw_valid_d, ar_valid_d, wr_ok_d, rd_ok_d;

    vfb_axi_master #(
        .BURST_LEN   (BURST_LEN),
        .LINE_PIXELS (LINE_PIXELS),
        .PIXEL_BITS  (PIXEL_BITS),
        .BASE_SEL    (BASE_SEL)
    ) dut (.*);

    initial begin
        M_AXI_ACLK = 1'b0;
        forever #10 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    always @(posedge M_AXI_ACLK) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("error: %s expected 0x%0h actual 0x%0h (cycle %0d)",
                     name, exp, act, cycle_cnt);
        end
    endtask

    function automatic int page_after(input int p);
        return (p + 1) % frame_buf_pkg::num_pages;
    endfunction

    // triple-buffer rule, both ends may land on one cycle
    task automatic rotate_pages(input logic wr_done, input logic rd_done);
        int rd_next;
        int cand;
        rd_next = rd_done ? m_last_wr : m_rd_page;
        if (wr_done) begin
            cand = page_after(m_wr_page);
            if (cand == rd_next)
                cand = page_after(cand);   // skip the reader's page
            m_last_wr = m_wr_page;
            m_wr_page = cand;
            m_ready   = 1'b1;
            wr_frames++;
        end
        if (rd_done) begin
            m_rd_page = rd_next;
            rd_frames++;
        end
    endtask

    // drive after the edge, check at the falling edge
    task automatic step_cycle();
        logic [31:0] r;
        logic        aw_hs, ar_hs, w_end, r_end;
        @(posedge M_AXI_ACLK);
        #2;
        r = next_rand();
        aw_ready              = r[31] & ~hold;
        ar_ready              = r[30] & ~hold;
        w_beat.ready_or_valid = r[29];
        r_beat.ready_or_valid = r[28];
        w_beat.last           = w_phase && (w_cnt == BURST_LEN - 1);
        r_beat.last           = r_phase && (r_cnt == BURST_LEN - 1);
        vs_in                 = vs_pulse;
        vs_out                = vs_pulse;
        if (block) begin
            wfifo_level = 9'(r[3:0] % (BURST_LEN + 1));
            rfifo_level = 9'(RD_THRESH + r[4:0]);
        end else begin
            wfifo_level = r[8:0];
            rfifo_level = r[17:9];
        end
        @(negedge M_AXI_ACLK);
        check_eq("wfifo_rd_req", w_phase & w_beat.ready_or_valid, wfifo_rd_req);
        check_eq("rfifo_wr_req", r_phase & r_beat.ready_or_valid, rfifo_wr_req);
        check_eq("aw valid in data phase", 0, aw.valid & w_phase);
        check_eq("ar valid in data phase", 0, ar.valid & r_phase);
        check_eq("frame_ready early", 0, frame_ready & ~m_ready);
        if (aw.valid && !aw_valid_d)
            check_eq("aw start watermark", 1, wr_ok_d);   // level seen at the last edge
        if (ar.valid && !ar_valid_d) begin
            check_eq("ar start watermark", 1, rd_ok_d);
            check_eq("ar before first frame", 1, m_ready);
        end
        aw_hs = aw.valid & aw_ready;
        ar_hs = ar.valid & ar_ready;
        w_end = 1'b0;
        r_end = 1'b0;
        if (w_phase && w_beat.ready_or_valid) begin
            w_cnt++;
            if (w_beat.last)
                w_phase = 1'b0;
        end
        if (r_phase && r_beat.ready_or_valid) begin
            r_cnt++;
            if (r_beat.last)
                r_phase = 1'b0;
        end
        if (aw_hs) begin
            check_eq("aw pad and base", BASE_SEL, aw.addr.flat[27:22]);
            check_eq("aw page", m_wr_page, aw.addr.flat[21:20]);
            check_eq("aw offset", m_wr_ofs, aw.addr.flat[19:0]);
            w_end    = (m_wr_ofs >= FRAME_END - STEP);
            m_wr_ofs = w_end ? FRAME_FIRST : m_wr_ofs + STEP;
            w_phase  = 1'b1;
            w_cnt    = 0;
        end
        if (ar_hs) begin
            check_eq("ar pad and base", BASE_SEL, ar.addr.flat[27:22]);
            check_eq("ar page", m_rd_page, ar.addr.flat[21:20]);
            check_eq("ar offset", m_rd_ofs, ar.addr.flat[19:0]);
            r_end    = (m_rd_ofs >= FRAME_END - STEP);
            m_rd_ofs = r_end ? FRAME_FIRST : m_rd_ofs + STEP;
            r_phase  = 1'b1;
            r_cnt    = 0;
        end
        if (w_end || r_end)
            rotate_pages(w_end, r_end);
        aw_valid_d = aw.valid;
        ar_valid_d = ar.valid;
        wr_ok_d    = (wfifo_level > BURST_LEN);
        rd_ok_d    = (rfifo_level < RD_THRESH);
    endtask

    task automatic run_frames(input int n);
        while (wr_frames < n || rd_frames + 4 < n)
            step_cycle();
    endtask

    // vsync pulse on both sides in mid frame with the address channels stalled
    task automatic restart_streams();
        while (m_wr_ofs == FRAME_FIRST || m_rd_ofs == FRAME_FIRST)
            step_cycle();   // both counters away from the frame start
        hold = 1'b1;
        while (w_phase || r_phase)
            step_cycle();
        vs_pulse = 1'b1;
        step_cycle();
        vs_pulse = 1'b0;
        m_wr_ofs = FRAME_FIRST;   // pages stay as they are
        m_rd_ofs = FRAME_FIRST;
        repeat (8) step_cycle();
        hold = 1'b0;
    endtask

    initial begin
        M_AXI_ARESETN     = 1'b0;
        ddr_init_done     = 1'b0;
        frame_win.first   = FRAME_FIRST;
        frame_win.end_ofs = FRAME_END;
        vs_in             = 1'b0;
        vs_out            = 1'b0;
        wfifo_level       = '0;
        rfifo_level       = '0;
        aw_ready          = 1'b0;
        ar_ready          = 1'b0;
        w_beat            = '0;
        r_beat            = '0;
        {hold, block, vs_pulse, w_phase, r_phase, m_ready} = '0;
        {aw_valid_d, ar_valid_d, wr_ok_d, rd_ok_d} = '0;
        {w_cnt, r_cnt, m_wr_ofs, m_rd_ofs} = '0;
        {m_wr_page, m_rd_page, m_last_wr, wr_frames, rd_frames} = '0;
        repeat (4) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        check_eq("aw valid in reset", 0, aw.valid);
        check_eq("ar valid in reset", 0, ar.valid);
        check_eq("frame_ready in reset", 0, frame_ready);
        @(posedge M_AXI_ACLK);
        #2;
        M_AXI_ARESETN = 1'b1;
        ddr_init_done = 1'b1;
        run_frames(6);
        block = 1'b1;   // no burst may start in here
        repeat (60) step_cycle();
        block = 1'b0;
        run_frames(12);
        restart_streams();
        run_frames(18);
        restart_streams();
        run_frames(24);
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sim/vfb_axi_master_props.sv
module vfb_axi_master_props (
    input logic                     M_AXI_ACLK,
    input logic                     M_AXI_ARESETN,
    input axi_burst_pkg::addr_req_t aw,
    input logic                     aw_ready,
    input logic                     wr_restart,
    input axi_burst_pkg::addr_req_t ar,
    input logic                     ar_ready,
    input logic                     rd_restart,
    input frame_buf_pkg::page_t     wr_page,
    input frame_buf_pkg::page_t     rd_page,
    input logic                     frame_ready
);

    // a restart may pull valid back without a handshake
    aw_held: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        aw.valid && !aw_ready && !wr_restart |=> aw.valid && $stable(aw.addr))
        else $error("AW valid dropped or address moved before ready");

    ar_held: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        ar.valid && !ar_ready && !rd_restart |=> ar.valid && $stable(ar.addr))
        else $error("AR valid dropped or address moved before ready");

    ar_gated: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        ar.valid |-> frame_ready)
        else $error("AR valid before the first frame was written");

    pages_apart: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        frame_ready |-> wr_page != rd_page)
        else $error("writer and reader share one page");

endmodule

bind vfb_axi_master vfb_axi_master_props u_props (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .aw            (aw),
    .aw_ready      (aw_ready),
    .wr_restart    (u_wr.restart),
    .ar            (ar),
    .ar_ready      (ar_ready),
    .rd_restart    (u_rd.restart),
    .wr_page       (wr_page),
    .rd_page       (rd_page),
    .frame_ready   (frame_ready)
);

// File: logic/vfb_axi_master.sv
module vfb_axi_master #(
    parameter int BURST_LEN   = 8,
    parameter int LINE_PIXELS = 1920,
    parameter int PIXEL_BITS  = 32,
    parameter int BASE_SEL    = 0
) (
    input  logic                         ddr_init_done,
    input  logic                         M_AXI_ACLK,
    input  logic                         M_AXI_ARESETN,
    input  frame_buf_pkg::frame_window_t frame_win,
    input  logic                         vs_in,
    input  logic                         vs_out,
    input  logic [8:0]                   wfifo_level,
    input  logic [8:0]                   rfifo_level,
    // write side
    output axi_burst_pkg::addr_req_t     aw,
    input  logic                         aw_ready,
    input  axi_burst_pkg::beat_t         w_beat,
    // read side
    output axi_burst_pkg::addr_req_t     ar,
    input  logic                         ar_ready,
    input  axi_burst_pkg::beat_t         r_beat,
    // FIFO requests and status
    output logic                         wfifo_rd_req,
    output logic                         rfifo_wr_req,
    output logic                         frame_ready
);

    logic                 wr_frame_done;
    logic                 rd_frame_done;
    frame_buf_pkg::page_t wr_page;
    frame_buf_pkg::page_t rd_page;

    wr_burst_ctrl #(
        .BURST_LEN (BURST_LEN),
        .BASE_SEL  (BASE_SEL)
    ) u_wr (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .ddr_init_done (ddr_init_done),
        .frame_win     (frame_win),
        .vs_in         (vs_in),
        .wfifo_level   (wfifo_level),
        .page          (wr_page),
        .aw            (aw),
        .aw_ready      (aw_ready),
        .w_beat        (w_beat),
        .wfifo_rd_req  (wfifo_rd_req),
        .frame_done    (wr_frame_done)
    );

    rd_burst_ctrl #(
        .BURST_LEN   (BURST_LEN),
        .LINE_PIXELS (LINE_PIXELS),
        .PIXEL_BITS  (PIXEL_BITS),
        .BASE_SEL    (BASE_SEL)
    ) u_rd (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .ddr_init_done (ddr_init_done),
        .frame_ready   (frame_ready),
        .frame_win     (frame_win),
        .vs_out        (vs_out),
        .rfifo_level   (rfifo_level),
        .page          (rd_page),
        .ar            (ar),
        .ar_ready      (ar_ready),
        .r_beat        (r_beat),
        .rfifo_wr_req  (rfifo_wr_req),
        .frame_done    (rd_frame_done)
    );

    // page rotation between the two streams
    frame_page_mgr u_pages (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .wr_frame_done (wr_frame_done),
        .rd_frame_done (rd_frame_done),
        .wr_page       (wr_page),
        .rd_page       (rd_page),
        .frame_ready   (frame_ready)
    );

endmodule

// File: logic/frame_page_mgr.sv
module frame_page_mgr (
    input  logic                 M_AXI_ACLK,
    input  logic                 M_AXI_ARESETN,
    input  logic                 wr_frame_done,
    input  logic                 rd_frame_done,
    output frame_buf_pkg::page_t wr_page,
    output frame_buf_pkg::page_t rd_page,
    output logic                 frame_ready
);

    frame_buf_pkg::page_t last_wr;      // most recently completed write page
    frame_buf_pkg::page_t rd_page_nxt;
    frame_buf_pkg::page_t wr_cand;
    frame_buf_pkg::page_t wr_page_nxt;

    // increment modulo num_pages
    function automatic frame_buf_pkg::page_t next_page(input frame_buf_pkg::page_t p);
        frame_buf_pkg::page_t top;
        top = frame_buf_pkg::page_t'(frame_buf_pkg::num_pages - 1);
        return (p == top) ? '0 : p + 2'd1;
    endfunction

    // read page as it stands after this cycle
    assign rd_page_nxt = rd_frame_done ? last_wr : rd_page;

    // skip over the page the reader will hold
    assign wr_cand     = next_page(wr_page);
    assign wr_page_nxt = (wr_cand == rd_page_nxt) ? next_page(wr_cand) : wr_cand;

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wr_page     <= '0;
            rd_page     <= '0;
            last_wr     <= '0;
            frame_ready <= 1'b0;
        end else begin
            if (wr_frame_done) begin
                wr_page     <= wr_page_nxt;
                last_wr     <= wr_page;
                frame_ready <= 1'b1;   // sticky from the first full frame
            end
            if (rd_frame_done)
                rd_page <= last_wr;    // old value, also on a shared cycle
        end
    end

endmodule

// File: logic/rd_burst_ctrl.sv
module rd_burst_ctrl #(
    parameter int BURST_LEN   = 8,
    parameter int LINE_PIXELS = 1920,
    parameter int PIXEL_BITS  = 32,
    parameter int BASE_SEL    = 0
) (
    input  logic                         M_AXI_ACLK,
    input  logic                         M_AXI_ARESETN,
    input  logic                         ddr_init_done,
    input  logic                         frame_ready,
    input  frame_buf_pkg::frame_window_t frame_win,
    input  logic                         vs_out,
    input  logic [8:0]                   rfifo_level,
    input  frame_buf_pkg::page_t         page,
    output axi_burst_pkg::addr_req_t     ar,
    input  logic                         ar_ready,
    input  axi_burst_pkg::beat_t         r_beat,
    output logic                         rfifo_wr_req,
    output logic                         frame_done
);

    localparam frame_buf_pkg::word_ofs_t STEP =
        frame_buf_pkg::word_ofs_t'(BURST_LEN * axi_burst_pkg::beat_words);
    // one video line in 128-bit FIFO entries
    localparam int LINE_THRESH = LINE_PIXELS * PIXEL_BITS / 128;

    axi_burst_pkg::burst_state_e state;
    frame_buf_pkg::word_ofs_t    ofs;
    frame_buf_pkg::word_ofs_t    last_ofs;
    logic [1:0]                  vs_sync;
    logic                        vs_prev;
    logic                        vs_rise;
    logic                        restart_pend;
    logic                        restart;
    logic                        addr_hs;
    logic                        last_burst;
    logic                        start_ok;
    logic                        beat_last;

    assign vs_rise    = vs_sync[1] & ~vs_prev;
    assign addr_hs    = ar.valid & ar_ready;
    assign last_ofs   = frame_win.end_ofs - STEP;
    assign last_burst = (ofs >= last_ofs);
    assign start_ok   = (rfifo_level < LINE_THRESH);   // room for more than a line
    assign beat_last  = (state == axi_burst_pkg::st_data) & r_beat.ready_or_valid & r_beat.last;
    assign restart    = restart_pend & (state != axi_burst_pkg::st_data) & ~addr_hs;

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            vs_sync <= '0;
            vs_prev <= 1'b0;
        end else begin
            vs_sync <= {vs_sync[0], vs_out};
            vs_prev <= vs_sync[1];
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN)
            restart_pend <= 1'b0;
        else if (vs_rise)
            restart_pend <= 1'b1;
        else if (restart)
            restart_pend <= 1'b0;
    end

    // read side stays idle until one whole frame is in DDR
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state <= axi_burst_pkg::st_idle;
        end else if (restart && state != axi_burst_pkg::st_idle) begin
            state <= axi_burst_pkg::st_start;
        end else begin
            case (state)
                axi_burst_pkg::st_idle:
                    if (ddr_init_done && frame_ready) state <= axi_burst_pkg::st_start;
                axi_burst_pkg::st_start: if (start_ok) state <= axi_burst_pkg::st_addr;
                axi_burst_pkg::st_addr:  if (addr_hs) state <= axi_burst_pkg::st_data;
                axi_burst_pkg::st_data:  if (beat_last) state <= axi_burst_pkg::st_start;
                default:                 state <= axi_burst_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN)
            ofs <= '0;
        else if (state == axi_burst_pkg::st_idle || restart)
            ofs <= frame_win.first;
        else if (addr_hs)
            ofs <= last_burst ? frame_win.first : ofs + STEP;
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN)
            frame_done <= 1'b0;
        else
            frame_done <= addr_hs & last_burst;   // one cycle after the last AR
    end

    always_comb begin
        ar                      = '0;
        ar.valid                = (state == axi_burst_pkg::st_addr);
        ar.addr.fields.base_sel = 2'(BASE_SEL);
        ar.addr.fields.page     = page;
        ar.addr.fields.ofs      = ofs;
    end

    assign rfifo_wr_req = (state == axi_burst_pkg::st_data) & r_beat.ready_or_valid;

endmodule

// File: logic/wr_burst_ctrl.sv
module wr_burst_ctrl #(
    parameter int BURST_LEN = 8,
    parameter int BASE_SEL  = 0
) (
    input  logic                         M_AXI_ACLK,
    input  logic                         M_AXI_ARESETN,
    input  logic                         ddr_init_done,
    input  frame_buf_pkg::frame_window_t frame_win,
    input  logic                         vs_in,
    input  logic [8:0]                   wfifo_level,
    input  frame_buf_pkg::page_t         page,
    output axi_burst_pkg::addr_req_t     aw,
    input  logic                         aw_ready,
    input  axi_burst_pkg::beat_t         w_beat,
    output logic                         wfifo_rd_req,
    output logic                         frame_done
);

    // words covered by one burst
    localparam frame_buf_pkg::word_ofs_t STEP =
        frame_buf_pkg::word_ofs_t'(BURST_LEN * axi_burst_pkg::beat_words);

    axi_burst_pkg::burst_state_e state;
    frame_buf_pkg::word_ofs_t    ofs;
    frame_buf_pkg::word_ofs_t    last_ofs;
    logic [1:0]                  vs_sync;
    logic                        vs_prev;
    logic                        vs_rise;
    logic                        restart_pend;
    logic                        restart;
    logic                        addr_hs;
    logic                        last_burst;
    logic                        start_ok;
    logic                        beat_last;

    assign vs_rise    = vs_sync[1] & ~vs_prev;
    assign addr_hs    = aw.valid & aw_ready;
    assign last_ofs   = frame_win.end_ofs - STEP;
    assign last_burst = (ofs >= last_ofs);
    assign start_ok   = (wfifo_level > BURST_LEN);   // enough data for a full burst
    assign beat_last  = (state == axi_burst_pkg::st_data) & w_beat.ready_or_valid & w_beat.last;

    // a handshake in flight wins over a pending restart
    assign restart = restart_pend & (state != axi_burst_pkg::st_data) & ~addr_hs;

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            vs_sync <= '0;
            vs_prev <= 1'b0;
        end else begin
            vs_sync <= {vs_sync[0], vs_in};
            vs_prev <= vs_sync[1];
        end
    end

    // held until the data phase is over
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN)
            restart_pend <= 1'b0;
        else if (vs_rise)
            restart_pend <= 1'b1;
        else if (restart)
            restart_pend <= 1'b0;
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state <= axi_burst_pkg::st_idle;
        end else if (restart && state != axi_burst_pkg::st_idle) begin
            state <= axi_burst_pkg::st_start;   // drops valid
        end else begin
            case (state)
                axi_burst_pkg::st_idle:  if (ddr_init_done) state <= axi_burst_pkg::st_start;
                axi_burst_pkg::st_start: if (start_ok) state <= axi_burst_pkg::st_addr;
                axi_burst_pkg::st_addr:  if (addr_hs) state <= axi_burst_pkg::st_data;
                axi_burst_pkg::st_data:  if (beat_last) state <= axi_burst_pkg::st_start;
                default:                 state <= axi_burst_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN)
            ofs <= '0;
        else if (state == axi_burst_pkg::st_idle || restart)
            ofs <= frame_win.first;
        else if (addr_hs)
            ofs <= last_burst ? frame_win.first : ofs + STEP;   // wrap at frame end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN)
            frame_done <= 1'b0;
        else
            frame_done <= addr_hs & last_burst;
    end

    always_comb begin
        aw                      = '0;
        aw.valid                = (state == axi_burst_pkg::st_addr);
        aw.addr.fields.base_sel = 2'(BASE_SEL);
        aw.addr.fields.page     = page;
        aw.addr.fields.ofs      = ofs;
    end

    assign wfifo_rd_req = (state == axi_burst_pkg::st_data) & w_beat.ready_or_valid;

endmodule

// File: logic/axi_burst_pkg.sv
package axi_burst_pkg;

    // 256-bit beat covers eight 32-bit address units
    localparam int beat_words = 8;

    // shared by the write and read burst machines
    typedef enum logic [1:0] {
        st_idle,
        st_start,   // waiting on the FIFO watermark
        st_addr,    // address valid, waiting for ready
        st_data     // counting beats until last
    } burst_state_e;

    // one AW or AR request
    typedef struct packed {
        logic                   valid;
        frame_buf_pkg::fb_addr_u addr;
    } addr_req_t;

    // W ready or R valid, plus the last-beat flag
    typedef struct packed {
        logic ready_or_valid;
        logic last;
    } beat_t;

endpackage

// File: logic/frame_buf_pkg.sv
package frame_buf_pkg;

    // AXI byte address width seen by the DDR controller
    localparam int ctrl_addr_bits = 28;

    // triple buffering
    localparam int num_pages = 3;

    typedef logic [1:0]  page_t;
    typedef logic [19:0] word_ofs_t;   // 32-bit word offset inside one page

    // address layout, msb first
    typedef struct packed {
        logic [3:0] pad;       // always zero
        logic [1:0] base_sel;  // which frame-buffer region
        page_t      page;
        word_ofs_t  ofs;
    } fb_fields_t;

    // controllers build the fields, the AXI port takes the flat word
    typedef union packed {
        logic [ctrl_addr_bits-1:0] flat;
        fb_fields_t                fields;
    } fb_addr_u;

    // word range of one frame inside a page
    typedef struct packed {
        word_ofs_t first;    // first word of the frame
        word_ofs_t end_ofs;  // one past the last word
    } frame_window_t;

endpackage
